/* ctr_pkg.sv */
/* Shared register map, widths and bus/link structs
   for the dual 32-bit counter-timer */
`default_nettype none

package ctr_pkg;

    localparam int BUS_W = 32;              // Bus data and address width
    localparam int CFG_W = 5;               // Defined config bits

    // Register offsets inside one counter window
    localparam logic [BUS_W-1:0] CFG_OFS  = 32'h0000_0000;
    localparam logic [BUS_W-1:0] VAL_OFS  = 32'h0000_0004;
    localparam logic [BUS_W-1:0] DAT_OFS  = 32'h0000_0008;
    localparam logic [BUS_W-1:0] STAT_OFS = 32'h0000_000C;   // Low window only

    // Window bases
    localparam logic [BUS_W-1:0] LOW_BASE  = 32'h0000_0000;
    localparam logic [BUS_W-1:0] HIGH_BASE = 32'h0000_0010;

    // Config register, enable sits in bit 0
    typedef struct packed {
        logic irq_ena;                      // Interrupt on stop
        logic chain;                        // Part of a 64-bit pair
        logic updown;                       // 1 up, 0 down
        logic oneshot;                      // 1 one-shot, 0 continuous
        logic enable;                       // Run
    } ctr_cfg_t;

    // Write command toward one counter
    typedef struct packed {
        logic             cfg_we;           // Lane 0 only
        logic [3:0]       val_we;           // Byte mask
        logic [3:0]       dat_we;           // Byte mask
        logic [BUS_W-1:0] wdata;
    } ctr_wr_t;

    // Readback from one counter
    typedef struct packed {
        ctr_cfg_t         cfg;
        logic [BUS_W-1:0] val;              // Reload value
        logic [BUS_W-1:0] dat;              // Current count
    } ctr_rd_t;

    // Chaining signals between the two counters
    typedef struct packed {
        logic strobe;                       // Low word wrapped
        logic stop;                         // Terminal value reached
        logic enable;                       // Config enable
    } ctr_link_t;

endpackage

`default_nettype wire

/* ctr_low.sv */
/* Low-word counter-timer, standalone or chained,
   sends a count strobe to the high word on every wrap */
`timescale 1ns/1ns
`default_nettype none

module ctr_low import ctr_pkg::*; (
    input  logic      clkin,
    input  logic      resetn,
    input  ctr_wr_t   wr_i,
    output ctr_rd_t   rd_o,
    input  ctr_link_t peer_i,
    output ctr_link_t link_o,
    output logic      irq_o
);

    ctr_cfg_t         cfg;
    logic [BUS_W-1:0] val;                  // Reload register
    logic [BUS_W-1:0] dat;                  // Running count
    logic [BUS_W-1:0] term;                 // Terminal value
    logic [BUS_W-1:0] start;                // Load value on enable edge
    logic [BUS_W-1:0] nxt;
    logic             loc_en;
    logic             last_en;
    logic             stop;
    logic             last_stop;
    logic             strobe;
    logic             peer_done;            // 64-bit terminal needs high stopped

    assign term      = cfg.updown ? val : '0;
    assign start     = cfg.updown ? '0 : val;
    assign nxt       = cfg.updown ? dat + 1'b1 : dat - 1'b1;
    assign loc_en    = cfg.chain ? (cfg.enable & peer_i.enable) : cfg.enable;
    assign peer_done = ~cfg.chain | peer_i.stop;

    // Config and reload registers
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            cfg <= '0;
            val <= '0;
        end else begin
            if (wr_i.cfg_we)
                cfg <= ctr_cfg_t'(wr_i.wdata[CFG_W-1:0]);
            for (int b = 0; b < 4; b++) begin
                if (wr_i.val_we[b])
                    val[8*b +: 8] <= wr_i.wdata[8*b +: 8];
            end
        end
    end

    // Count engine
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            dat       <= '0;
            stop      <= 1'b0;
            last_stop <= 1'b0;
            last_en   <= 1'b0;
            strobe    <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            last_en   <= loc_en;
            last_stop <= stop;
            strobe    <= 1'b0;
            irq_o     <= cfg.irq_ena & stop & ~last_stop;   // Rising stop, one cycle late
            if (|wr_i.dat_we) begin
                // Software write wins over counting
                for (int b = 0; b < 4; b++) begin
                    if (wr_i.dat_we[b])
                        dat[8*b +: 8] <= wr_i.wdata[8*b +: 8];
                end
            end else if (!loc_en) begin
                stop <= 1'b0;
            end else if (!last_en) begin
                dat  <= start;                  // Enable edge
                stop <= 1'b0;
            end else if (dat == term) begin
                if (cfg.chain && peer_i.stop && !stop)
                    stop <= 1'b1;               // Whole 64-bit value at terminal
                else if (cfg.oneshot && peer_done)
                    stop <= 1'b1;               // Freeze at terminal
                else begin
                    dat    <= start;            // Wrap
                    stop   <= 1'b0;
                    strobe <= cfg.chain;        // Carry into high word
                end
            end else begin
                dat  <= nxt;
                stop <= (nxt == term) & peer_done;
            end
        end
    end

    assign rd_o   = '{cfg: cfg, val: val, dat: dat};
    assign link_o = '{strobe: strobe, stop: stop, enable: cfg.enable};

endmodule

`default_nettype wire

/* ctr_high.sv */
/* High-word counter-timer, standalone or counting
   on the low word strobe as the top half of a 64-bit timer */
`timescale 1ns/1ns
`default_nettype none

module ctr_high import ctr_pkg::*; (
    input  logic      clkin,
    input  logic      resetn,
    input  ctr_wr_t   wr_i,
    output ctr_rd_t   rd_o,
    input  ctr_link_t peer_i,
    output ctr_link_t link_o,
    output logic      irq_o
);

    ctr_cfg_t         cfg;
    logic [BUS_W-1:0] val;                  // Reload register
    logic [BUS_W-1:0] dat;                  // Running count
    logic [BUS_W-1:0] term;
    logic [BUS_W-1:0] start;
    logic [BUS_W-1:0] nxt;
    logic             loc_en;
    logic             last_en;
    logic             stop;
    logic             done;                 // Stop of the whole timer
    logic             last_done;

    assign term   = cfg.updown ? val : '0;
    assign start  = cfg.updown ? '0 : val;
    assign nxt    = cfg.updown ? dat + 1'b1 : dat - 1'b1;
    assign loc_en = cfg.chain ? (cfg.enable & peer_i.enable) : cfg.enable;

    // Chained, the interrupt waits for the low word to finish too
    assign done = stop & (~cfg.chain | peer_i.stop);

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            cfg <= '0;
            val <= '0;
        end else begin
            if (wr_i.cfg_we)
                cfg <= ctr_cfg_t'(wr_i.wdata[CFG_W-1:0]);
            for (int b = 0; b < 4; b++) begin
                if (wr_i.val_we[b])
                    val[8*b +: 8] <= wr_i.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            dat       <= '0;
            stop      <= 1'b0;
            last_en   <= 1'b0;
            last_done <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            last_en   <= loc_en;
            last_done <= done;
            irq_o     <= cfg.irq_ena & done & ~last_done;
            if (|wr_i.dat_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_i.dat_we[b])
                        dat[8*b +: 8] <= wr_i.wdata[8*b +: 8];
                end
            end else if (!loc_en) begin
                stop <= 1'b0;
            end else if (!last_en) begin
                dat  <= start;                  // Enable edge
                stop <= 1'b0;
            end else if (cfg.chain) begin
                if (peer_i.stop) begin
                    // Low word done, reload both halves unless one-shot
                    if (!cfg.oneshot) begin
                        dat  <= start;
                        stop <= 1'b0;
                    end
                end else if (peer_i.strobe && !stop) begin
                    dat  <= nxt;                // Carry from low word
                    stop <= (nxt == term);
                end else if (dat == term) begin
                    stop <= 1'b1;               // Reload of zero on down count
                end
            end else if (dat == term) begin
                if (cfg.oneshot)
                    stop <= 1'b1;
                else begin
                    dat  <= start;
                    stop <= 1'b0;
                end
            end else begin
                dat  <= nxt;
                stop <= (nxt == term);
            end
        end
    end

    assign rd_o = '{cfg: cfg, val: val, dat: dat};

    // No carry out of the top word
    assign link_o = '{strobe: 1'b0, stop: stop, enable: cfg.enable};

endmodule

`default_nettype wire

/* ctr_bus.sv */
/* Bus slave: address decode, registered ack, write commands,
   read mux and sticky interrupt status */
`timescale 1ns/1ns
`default_nettype none

module ctr_bus import ctr_pkg::*; (
    input  logic             clkin,
    input  logic             resetn,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [3:0]       wb_sel_i,
    input  logic [BUS_W-1:0] wb_adr_i,
    input  logic [BUS_W-1:0] wb_dat_i,
    output logic             wb_ack_o,
    output logic [BUS_W-1:0] wb_dat_o,
    output ctr_wr_t          low_wr_o,
    output ctr_wr_t          high_wr_o,
    input  ctr_rd_t          low_rd_i,
    input  ctr_rd_t          high_rd_i,
    input  logic             low_irq_i,
    input  logic             high_irq_i,
    output logic             irq_o
);

    logic             valid;
    logic             req;                  // First cycle of an access
    logic             wr;
    logic             hit_lcfg, hit_lval, hit_ldat, hit_stat;
    logic             hit_hcfg, hit_hval, hit_hdat;
    logic [1:0]       stat;                 // Bit 0 low, bit 1 high
    logic [1:0]       stat_clr;
    logic [BUS_W-1:0] rdata;
    logic [BUS_W-1:0] rdat_q;

    assign valid = wb_cyc_i & wb_stb_i;
    assign req   = valid & ~wb_ack_o;
    assign wr    = req & wb_we_i;

    // Exact match decode
    assign hit_lcfg = (wb_adr_i == (LOW_BASE | CFG_OFS));
    assign hit_lval = (wb_adr_i == (LOW_BASE | VAL_OFS));
    assign hit_ldat = (wb_adr_i == (LOW_BASE | DAT_OFS));
    assign hit_stat = (wb_adr_i == (LOW_BASE | STAT_OFS));
    assign hit_hcfg = (wb_adr_i == (HIGH_BASE | CFG_OFS));
    assign hit_hval = (wb_adr_i == (HIGH_BASE | VAL_OFS));
    assign hit_hdat = (wb_adr_i == (HIGH_BASE | DAT_OFS));

    // Write commands, all zero outside the write cycle
    always_comb begin
        low_wr_o.cfg_we  = wr & hit_lcfg & wb_sel_i[0];
        low_wr_o.val_we  = wb_sel_i & {4{wr & hit_lval}};
        low_wr_o.dat_we  = wb_sel_i & {4{wr & hit_ldat}};
        low_wr_o.wdata   = (wr & (hit_lcfg | hit_lval | hit_ldat)) ? wb_dat_i : '0;
        high_wr_o.cfg_we = wr & hit_hcfg & wb_sel_i[0];
        high_wr_o.val_we = wb_sel_i & {4{wr & hit_hval}};
        high_wr_o.dat_we = wb_sel_i & {4{wr & hit_hdat}};
        high_wr_o.wdata  = (wr & (hit_hcfg | hit_hval | hit_hdat)) ? wb_dat_i : '0;
    end

    // Read mux, unmapped reads zero
    always_comb begin
        rdata = '0;
        if (hit_lcfg)      rdata = {{(BUS_W-CFG_W){1'b0}}, low_rd_i.cfg};
        else if (hit_lval) rdata = low_rd_i.val;
        else if (hit_ldat) rdata = low_rd_i.dat;
        else if (hit_stat) rdata = {{(BUS_W-2){1'b0}}, stat};
        else if (hit_hcfg) rdata = {{(BUS_W-CFG_W){1'b0}}, high_rd_i.cfg};
        else if (hit_hval) rdata = high_rd_i.val;
        else if (hit_hdat) rdata = high_rd_i.dat;
    end

    assign stat_clr = (wr & hit_stat & wb_sel_i[0]) ? wb_dat_i[1:0] : 2'b00;

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            wb_ack_o <= 1'b0;
            rdat_q   <= '0;
            stat     <= 2'b00;
        end else begin
            wb_ack_o <= req;                    // One-cycle ack
            if (req)
                rdat_q <= rdata;                // Held while ack is high
            stat <= (stat & ~stat_clr) | {high_irq_i, low_irq_i};   // New pulse beats clear
        end
    end

    assign wb_dat_o = rdat_q;
    assign irq_o    = |stat;

endmodule

`default_nettype wire

/* ctr_top.sv */
/* Top level, bus slave plus the cross-linked
   low and high counter-timers */
`timescale 1ns/1ns
`default_nettype none

module ctr_top import ctr_pkg::*; (
    input  logic             clkin,
    input  logic             resetn,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [3:0]       wb_sel_i,
    input  logic [BUS_W-1:0] wb_adr_i,
    input  logic [BUS_W-1:0] wb_dat_i,
    output logic             wb_ack_o,
    output logic [BUS_W-1:0] wb_dat_o,
    output logic             irq_o
);

    ctr_wr_t   low_wr, high_wr;
    ctr_rd_t   low_rd, high_rd;
    ctr_link_t low_link, high_link;         // Crossed between the counters
    logic      low_irq, high_irq;

    ctr_bus i_ctr_bus (
        .clkin      (clkin),
        .resetn     (resetn),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_sel_i   (wb_sel_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_o   (wb_ack_o),
        .wb_dat_o   (wb_dat_o),
        .low_wr_o   (low_wr),
        .high_wr_o  (high_wr),
        .low_rd_i   (low_rd),
        .high_rd_i  (high_rd),
        .low_irq_i  (low_irq),
        .high_irq_i (high_irq),
        .irq_o      (irq_o)
    );

    ctr_low i_ctr_low (
        .clkin  (clkin),
        .resetn (resetn),
        .wr_i   (low_wr),
        .rd_o   (low_rd),
        .peer_i (high_link),
        .link_o (low_link),
        .irq_o  (low_irq)
    );

    ctr_high i_ctr_high (
        .clkin  (clkin),
        .resetn (resetn),
        .wr_i   (high_wr),
        .rd_o   (high_rd),
        .peer_i (low_link),
        .link_o (high_link),
        .irq_o  (high_irq)
    );

endmodule

`default_nettype wire

/* ctr_asserts.sv */
/* Concurrent checks on the bus handshake, counter
   interrupt pulses and interrupt output, bound into the bus slave */
`timescale 1ns/1ns
`default_nettype none

module ctr_asserts (
    input logic       clkin_i,
    input logic       resetn_i,
    input logic       valid_i,              // cyc and stb
    input logic       ack_i,
    input logic       low_irq_i,
    input logic       high_irq_i,
    input logic       irq_i
);

    a_ack_single: assert property (@(posedge clkin_i) disable iff (!resetn_i)
        ack_i |=> !ack_i)
        else $error("ack high for more than one cycle");

    // Ack only answers a cycle the master started
    a_ack_valid: assert property (@(posedge clkin_i) disable iff (!resetn_i)
        ack_i |-> $past(valid_i))
        else $error("ack without a valid bus cycle");

    a_low_pulse: assert property (@(posedge clkin_i) disable iff (!resetn_i)
        low_irq_i |=> !low_irq_i)
        else $error("low counter irq longer than one cycle");

    a_high_pulse: assert property (@(posedge clkin_i) disable iff (!resetn_i)
        high_irq_i |=> !high_irq_i)
        else $error("high counter irq longer than one cycle");

    // A counter pulse reaches the interrupt line next cycle, even against a clear
    a_irq_follow: assert property (@(posedge clkin_i) disable iff (!resetn_i)
        (low_irq_i || high_irq_i) |=> irq_i)
        else $error("counter irq pulse did not raise the interrupt output");

endmodule

bind ctr_bus ctr_asserts i_ctr_asserts (
    .clkin_i    (clkin),
    .resetn_i   (resetn),
    .valid_i    (valid),
    .ack_i      (wb_ack_o),
    .low_irq_i  (low_irq_i),
    .high_irq_i (high_irq_i),
    .irq_i      (irq_o)
);

`default_nettype wire

/* tb_clkgen.sv */
/* Free-running testbench clock,
   8 ns period */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic clk_o
);

    localparam int HALF = 4;                // Half period in ns

    initial begin
        clk_o = 1'b0;
        forever #(HALF) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* tb_ctr.sv */
/* Directed testbench for the counter-timer pair: bus tasks, register,
   count, chain and interrupt tests, cycle limit and verdict */
`timescale 1ns/1ns
`default_nettype none

module tb_ctr import ctr_pkg::*; ();

    localparam int MAX_CYCLES = 20000;      // Chained run needs up to 64x64 cycles
    localparam logic [BUS_W-1:0] EN  = 32'h01;   // Config bit 0
    localparam logic [BUS_W-1:0] ONE = 32'h02;   // One-shot
    localparam logic [BUS_W-1:0] UP  = 32'h04;
    localparam logic [BUS_W-1:0] CHN = 32'h08;
    localparam logic [BUS_W-1:0] IRQ = 32'h10;
    localparam logic [BUS_W-1:0] A_LCFG = LOW_BASE | CFG_OFS;
    localparam logic [BUS_W-1:0] A_LVAL = LOW_BASE | VAL_OFS;
    localparam logic [BUS_W-1:0] A_LDAT = LOW_BASE | DAT_OFS;
    localparam logic [BUS_W-1:0] A_STAT = LOW_BASE | STAT_OFS;
    localparam logic [BUS_W-1:0] A_HCFG = HIGH_BASE | CFG_OFS;
    localparam logic [BUS_W-1:0] A_HVAL = HIGH_BASE | VAL_OFS;
    localparam logic [BUS_W-1:0] A_HDAT = HIGH_BASE | DAT_OFS;
    localparam logic [BUS_W-1:0] A_HGAP = HIGH_BASE | STAT_OFS;   // No status in high window
    localparam logic [BUS_W-1:0] A_NONE = 32'h0000_0020;

    logic             clkin;
    logic             resetn;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [3:0]       wb_sel;
    logic [BUS_W-1:0] wb_adr;
    logic [BUS_W-1:0] wb_dat_w;
    logic [BUS_W-1:0] wb_dat_r;
    logic             wb_ack;
    logic             irq;
    int               errors = 0;
    int               checks = 0;
    int               cycles = 0;

    tb_clkgen i_clkgen (.clk_o(clkin));

    ctr_top i_ctr_top (
        .clkin    (clkin),
        .resetn   (resetn),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_sel_i (wb_sel),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_dat_r),
        .irq_o    (irq)
    );

    always @(posedge clkin) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped at the cycle limit of %0d", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // One access, signals held until ack seen on a falling edge
    task automatic handshake(input logic we, input logic [BUS_W-1:0] adr,
                             input logic [3:0] sel, input logic [BUS_W-1:0] wdat,
                             output logic [BUS_W-1:0] rdat);
        int n;
        n = 0;
        @(negedge clkin);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_sel   = sel;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge clkin);
            n++;
        end while (!wb_ack && n < 8);
        if (!wb_ack) begin
            errors++;
            $display("No ack for the access to address %h", adr);
        end
        rdat   = wb_dat_r;                  // Valid while ack high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [BUS_W-1:0] adr, input logic [3:0] sel,
                             input logic [BUS_W-1:0] data);
        logic [BUS_W-1:0] unused;
        handshake(1'b1, adr, sel, data, unused);
    endtask

    task automatic bus_read(input logic [BUS_W-1:0] adr, output logic [BUS_W-1:0] data);
        handshake(1'b0, adr, 4'hF, '0, data);
    endtask

    task automatic read_expect(input logic [BUS_W-1:0] adr, input string name,
                               input logic [BUS_W-1:0] exp);
        logic [BUS_W-1:0] rd;
        bus_read(adr, rd);
        checks++;
        if (rd !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, rd, exp);
        end
    endtask

    // Poll status until every bit of mask is set, bounded
    task automatic wait_status(input logic [1:0] mask, input int limit);
        logic [BUS_W-1:0] rd;
        int n;
        n  = 0;
        rd = '0;
        while ((rd[1:0] & mask) != mask && n < limit) begin
            bus_read(A_STAT, rd);
            n++;
        end
        checks++;
        if ((rd[1:0] & mask) != mask) begin
            errors++;
            $display("Status bits %b never set after %0d reads", mask, n);
        end
    endtask

    task automatic test_registers();
        read_expect(A_LCFG, "low cfg", '0);
        read_expect(A_LVAL, "low val", '0);
        read_expect(A_LDAT, "low dat", '0);
        read_expect(A_STAT, "status", '0);
        read_expect(A_HCFG, "high cfg", '0);
        read_expect(A_HVAL, "high val", '0);
        read_expect(A_HDAT, "high dat", '0);
        bus_write(A_LCFG, 4'hF, 32'hFFFF_FFFE);
        read_expect(A_LCFG, "low cfg", 32'h0000_001E);   // Five bits, enable kept off
        bus_write(A_LCFG, 4'hF, '0);
        bus_write(A_HVAL, 4'b0101, 32'hAABB_CCDD);
        read_expect(A_HVAL, "high val", 32'h00BB_00DD);
        bus_write(A_HVAL, 4'b1010, 32'h1122_3344);
        read_expect(A_HVAL, "high val", 32'h11BB_33DD);
        bus_write(A_HVAL, 4'hF, '0);
        bus_write(A_NONE, 4'hF, 32'hFFFF_FFFF);           // Must land nowhere
        read_expect(A_NONE, "unmapped", '0);
        read_expect(A_HGAP, "high gap", '0);
        read_expect(A_STAT, "status", '0);
    endtask

    task automatic test_down_oneshot();
        logic [BUS_W-1:0] n;
        n = ($urandom % 63) + 1;
        bus_write(A_LVAL, 4'hF, n);
        bus_write(A_LCFG, 4'hF, EN | ONE | IRQ);
        wait_status(2'b01, 100);
        read_expect(A_LDAT, "low dat", '0);
        read_expect(A_LDAT, "low dat", '0);               // Held at terminal
        read_expect(A_HDAT, "high dat", '0);
        read_expect(A_STAT, "status", 32'h1);
        bus_write(A_STAT, 4'h1, 32'h3);
        bus_write(A_LCFG, 4'hF, '0);
    endtask

    task automatic test_up_continuous();
        logic [BUS_W-1:0] n;
        logic [BUS_W-1:0] rd;
        n = ($urandom % 63) + 1;
        bus_write(A_LVAL, 4'hF, n);
        bus_write(A_LCFG, 4'hF, EN | UP);
        repeat (12) begin
            bus_read(A_LDAT, rd);
            checks++;
            if (rd > n) begin
                errors++;
                $display("ERR low dat got %h above reload %h", rd, n);
            end
        end
        read_expect(A_STAT, "status", '0);                // No irq_ena, no status
        bus_write(A_LCFG, 4'hF, '0);
    endtask

    task automatic test_chained();
        logic [BUS_W-1:0] l;
        logic [BUS_W-1:0] h;
        l = $urandom % 64;
        h = $urandom % 64;
        bus_write(A_LVAL, 4'hF, l);
        bus_write(A_HVAL, 4'hF, h);
        bus_write(A_LCFG, 4'hF, EN | ONE | CHN);
        bus_write(A_HCFG, 4'hF, EN | ONE | CHN | IRQ);    // Pair starts here
        wait_status(2'b10, 2500);                         // Two cycles per status read
        read_expect(A_STAT, "status", 32'h2);
        read_expect(A_LDAT, "low dat", '0);
        read_expect(A_HDAT, "high dat", '0);
        bus_write(A_STAT, 4'h1, 32'h3);
        bus_write(A_LCFG, 4'hF, '0);
        bus_write(A_HCFG, 4'hF, '0);
    endtask

    task automatic test_irq_combine();
        bus_write(A_LVAL, 4'hF, ($urandom % 63) + 1);
        bus_write(A_HVAL, 4'hF, ($urandom % 63) + 1);
        bus_write(A_LCFG, 4'hF, EN | ONE | IRQ);
        bus_write(A_HCFG, 4'hF, EN | ONE | IRQ);
        wait_status(2'b11, 100);
        checks++;
        if (irq !== 1'b1) begin
            errors++;
            $display("ERR irq_o got %h expected %h", irq, 1'b1);
        end
        bus_write(A_STAT, 4'h1, 32'h1);
        read_expect(A_STAT, "status", 32'h2);
        checks++;
        if (irq !== 1'b1) begin
            errors++;
            $display("ERR irq_o got %h expected %h", irq, 1'b1);
        end
        bus_write(A_STAT, 4'h1, 32'h2);
        read_expect(A_STAT, "status", '0);
        checks++;
        if (irq !== 1'b0) begin
            errors++;
            $display("ERR irq_o got %h expected %h", irq, 1'b0);
        end
        bus_write(A_LCFG, 4'hF, '0);
        bus_write(A_HCFG, 4'hF, '0);
    endtask

    task automatic test_dat_write();
        logic [BUS_W-1:0] rd;
        int t0;
        bus_write(A_LVAL, 4'hF, 32'd60);
        bus_write(A_LCFG, 4'hF, EN | ONE | IRQ);
        bus_write(A_LDAT, 4'hF, 32'd3);                   // Jump close to terminal
        t0 = cycles;
        bus_read(A_LDAT, rd);
        checks++;
        if (rd > 32'd3) begin
            errors++;
            $display("ERR low dat got %h expected at most %h", rd, 32'd3);
        end
        wait_status(2'b01, 100);
        checks++;
        if (cycles - t0 > 24) begin
            errors++;
            $display("Stop came %0d cycles after the dat write", cycles - t0);
        end
        bus_write(A_STAT, 4'h1, 32'h3);
        bus_write(A_LCFG, 4'hF, '0);
    endtask

    initial begin
        void'($urandom(32'hcdf5));
        resetn   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_sel   = 4'h0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (8) @(negedge clkin);
        resetn = 1'b1;
        test_registers();
        test_down_oneshot();
        test_up_continuous();
        test_chained();
        test_irq_combine();
        test_dat_write();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
ctr_pkg.sv
ctr_low.sv
ctr_high.sv
ctr_bus.sv
ctr_top.sv
ctr_asserts.sv
tb_clkgen.sv
tb_ctr.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ctr
FILELIST := src.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Regression failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails on the fail message in the log or on a nonzero exit of the simulator
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
